/* src/viterbi_defines.svh */
`ifndef VITERBI_DEFINES_SVH
`define VITERBI_DEFINES_SVH

// code geometry
`define MAX_CONSTR_LEN  9       // polynomial taps, K up to 9
`define MAX_CODE_RATE   3       // output bits per info bit, rate 1/3 max
`define STATE_REG_NUM   8       // shift register bits, K - 1 at K = 9

// radix-4 trellis scan
`define RADIX           4       // two info bits per branch
`define TABLE_DEPTH     1024    // radix * 2^(K-1) at K = 9
`define TABLE_ADDR_W    10      // {state, pair} address width

// run length counter
`define NUM_BITS_W      16      // encode run length width

// constraint length codes for code_cfg_t.constr_len
`define CONSTR_K3       2'd0
`define CONSTR_K5       2'd1
`define CONSTR_K7       2'd2
`define CONSTR_K9       2'd3

// table mode scan sizes, one entry per {state, pair}
`define SCAN_LAST_K3    10'd15   // 4 * 4 - 1
`define SCAN_LAST_K5    10'd63   // 4 * 16 - 1

`endif

/* src/viterbi_pkg.sv */
`include "viterbi_defines.svh"

package viterbi_pkg;

    // run mode, picked at each start
    typedef enum logic
    {
        MODE_ENCODE = 1'b0,   // one code word per info bit
        MODE_TABLE  = 1'b1    // walk every radix-4 branch
    } codec_mode_e;

    // per-run code configuration, 30 bits
    typedef struct packed
    {
        logic                                             code_rate;  // 0 = 1/2, 1 = 1/3
        logic [1:0]                                       constr_len; // K = 3, 5, 7, 9
        logic [`MAX_CODE_RATE-1:0][`MAX_CONSTR_LEN-1:0]   gen_poly;   // bit 0 taps newest bit
    } code_cfg_t;

    // trellis scan index, also the branch table address
    typedef struct packed
    {
        logic [`STATE_REG_NUM-1:0]     state;   // start state of the branch
        logic [$clog2(`RADIX)-1:0]     pair;    // two info bits, minor
    } scan_idx_t;

    // one radix-4 branch, 16 bits
    typedef struct packed
    {
        logic [$clog2(`RADIX)-1:0]     pair;    // input pair, bit 0 first
        logic [`STATE_REG_NUM-1:0]     state;   // start state
        logic [`MAX_CODE_RATE-1:0]     second;  // code word of second step
        logic [`MAX_CODE_RATE-1:0]     first;   // code word of first step
    } branch_entry_t;

endpackage

/* src/codec_ctrl.sv */
`include "viterbi_defines.svh"

module codec_ctrl
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_start,       // run strobe taken only while idle
    input  viterbi_pkg::codec_mode_e    i_mode,
    input  viterbi_pkg::code_cfg_t      i_cfg,
    input  logic [`NUM_BITS_W-1:0]      i_num_bits,    // encode run length
    input  logic                        i_bit_valid,
    input  logic                        i_bit,
    input  logic                        i_last_write,  // entry strobe from encoder
    output viterbi_pkg::code_cfg_t      o_cfg,         // latched config
    output logic                        o_clear,       // encoder state clear
    output logic                        o_enc_valid,
    output logic                        o_enc_bit,
    output logic                        o_scan_valid,
    output viterbi_pkg::scan_idx_t      o_scan_idx,
    output logic                        o_busy,
    output logic                        o_done
);
    import viterbi_pkg::*;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ENCODE,
        ST_SCAN,
        ST_DRAIN
    } ctrl_state_e;

    ctrl_state_e                state;
    logic [`NUM_BITS_W-1:0]     last_bit;       // run length minus one
    logic [`NUM_BITS_W-1:0]     bit_cnt;        // accepted info bits
    logic [`TABLE_ADDR_W-1:0]   scan_cnt;       // {state, pair} walk
    logic [`TABLE_ADDR_W-1:0]   scan_last;      // last index for latched K
    logic                       entry_seen;     // last entry strobe went by
    logic                       start_ok;

    assign start_ok     = (state == ST_IDLE) && i_start;   // start ignored while busy
    assign o_clear      = start_ok;                        // state is zero the cycle after start
    assign o_enc_valid  = (state == ST_ENCODE) && i_bit_valid; // idle bits dropped
    assign o_enc_bit    = i_bit;
    assign o_scan_valid = (state == ST_SCAN);
    assign o_scan_idx   = scan_idx_t'(scan_cnt);           // pair-minor order
    assign o_busy       = (state != ST_IDLE);

    // 4 * 2^(K-1) branches
    always_comb
    begin
        case (o_cfg.constr_len)
            `CONSTR_K3: scan_last = `SCAN_LAST_K3;
            `CONSTR_K5: scan_last = `SCAN_LAST_K5;
            `CONSTR_K7: scan_last = 10'd255;
            default:    scan_last = `TABLE_ADDR_W'(`TABLE_DEPTH - 1);
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= ST_IDLE;
            o_cfg      <= '0;
            last_bit   <= '0;
            bit_cnt    <= '0;
            scan_cnt   <= '0;
            entry_seen <= 1'b0;
            o_done     <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;                                 // single cycle pulse
            case (state)
                ST_IDLE:
                begin
                    if (start_ok)
                    begin
                        o_cfg      <= i_cfg;
                        last_bit   <= i_num_bits - 1'b1;
                        bit_cnt    <= '0;
                        scan_cnt   <= '0;
                        entry_seen <= 1'b0;
                        state      <= (i_mode == MODE_TABLE) ? ST_SCAN : ST_ENCODE;
                    end
                end
                ST_ENCODE:
                begin
                    if (i_bit_valid)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit)
                        begin
                            o_done <= 1'b1;                 // lines up with last code word
                            state  <= ST_IDLE;
                        end
                    end
                end
                ST_SCAN:
                begin
                    scan_cnt <= scan_cnt + 1'b1;            // one index per cycle
                    if (scan_cnt == scan_last)
                        state <= ST_DRAIN;
                end
                ST_DRAIN:
                begin
                    if (entry_seen)
                    begin
                        o_done <= 1'b1;                     // one cycle after last write
                        state  <= ST_IDLE;
                    end
                    else if (i_last_write)
                        entry_seen <= 1'b1;                 // table writes on this edge
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // scan never steps past the last branch of the latched K
    a_scan_range: assert property (@(posedge clk) disable iff (!rst)
        o_scan_valid |-> (scan_cnt <= scan_last));

    // done always closes a run
    a_done_busy: assert property (@(posedge clk) disable iff (!rst)
        o_done |-> $past(o_busy));

endmodule

/* src/conv_encoder.sv */
`include "viterbi_defines.svh"

module conv_encoder
(
    input  logic                            clk,
    input  logic                            rst,
    input  viterbi_pkg::code_cfg_t          i_cfg,          // latched run config
    input  logic                            i_clear,        // zero the shift state
    input  logic                            i_enc_valid,
    input  logic                            i_enc_bit,
    input  logic                            i_scan_valid,
    input  viterbi_pkg::scan_idx_t          i_scan_idx,
    output logic                            o_code_valid,
    output logic [`MAX_CODE_RATE-1:0]       o_code,         // encode mode code word
    output logic                            o_entry_valid,
    output viterbi_pkg::branch_entry_t      o_entry         // table mode branch
);
    import viterbi_pkg::*;

    logic [`STATE_REG_NUM-1:0]      enc_state;      // past info bits with bit 0 newest
    logic [`MAX_CONSTR_LEN-1:0]     enc_window;     // state plus new bit
    logic [`MAX_CONSTR_LEN-1:0]     first_window;   // branch step one
    logic [`MAX_CONSTR_LEN-1:0]     second_window;  // branch step two
    logic [`MAX_CODE_RATE-1:0]      enc_word;
    logic [`MAX_CODE_RATE-1:0]      first_word;
    logic [`MAX_CODE_RATE-1:0]      second_word;

    // each output bit is the parity of the tapped window
    function automatic logic [`MAX_CODE_RATE-1:0] code_word
    (
        input code_cfg_t                    cfg,
        input logic [`MAX_CONSTR_LEN-1:0]   window
    );
        logic [`MAX_CODE_RATE-1:0] word;
        for (int i = 0; i < `MAX_CODE_RATE; i++)
        begin
            word[i] = ^(window & cfg.gen_poly[i]);  // taps above K are zero from caller
        end
        if (!cfg.code_rate)
            word[`MAX_CODE_RATE-1] = 1'b0;          // rate 1/2 drops the third bit
        return word;
    endfunction

    assign enc_window    = {enc_state, i_enc_bit};
    // first step appends pair bit 0
    assign first_window  = {i_scan_idx.state, i_scan_idx.pair[0]};
    // second step shifts once more and appends pair bit 1
    assign second_window = {i_scan_idx.state[`STATE_REG_NUM-2:0],
                            i_scan_idx.pair[0], i_scan_idx.pair[1]};

    assign enc_word    = code_word(i_cfg, enc_window);
    assign first_word  = code_word(i_cfg, first_window);
    assign second_word = code_word(i_cfg, second_window);

    // shift state and strobes
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            enc_state     <= '0;
            o_code_valid  <= 1'b0;
            o_entry_valid <= 1'b0;
        end
        else
        begin
            if (i_clear)
                enc_state <= '0;                    // fresh run
            else if (i_enc_valid)
                enc_state <= {enc_state[`STATE_REG_NUM-2:0], i_enc_bit};
            o_code_valid  <= i_enc_valid;           // word one cycle after bit
            o_entry_valid <= i_scan_valid;          // entry one cycle after index
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (i_enc_valid)
            o_code <= enc_word;
        if (i_scan_valid)
        begin
            o_entry.pair   <= i_scan_idx.pair;
            o_entry.state  <= i_scan_idx.state;
            o_entry.second <= second_word;
            o_entry.first  <= first_word;
        end
    end

    // control never mixes an encode bit with a scan index
    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
        !(i_enc_valid && i_scan_valid));

    // a valid code word is never unknown
    a_code_known: assert property (@(posedge clk) disable iff (!rst)
        o_code_valid |-> !$isunknown(o_code));

endmodule

/* src/trellis_table.sv */
`include "viterbi_defines.svh"

module trellis_table
#(
    parameter type payload_t = viterbi_pkg::branch_entry_t     // stored entry type
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_wr_en,
    input  viterbi_pkg::scan_idx_t  i_wr_addr,
    input  payload_t                i_wr_data,
    input  viterbi_pkg::scan_idx_t  i_rd_addr,
    output payload_t                o_rd_data    // one cycle after address
);

    payload_t mem [`TABLE_DEPTH];               // one entry per {state, pair}

    // synchronous write
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
    end

    // free running registered read port
    always_ff @(posedge clk)
    begin
        o_rd_data <= mem[i_rd_addr];
    end

    // a write never lands on an unknown address
    a_wr_known: assert property (@(posedge clk) disable iff (!rst)
        i_wr_en |-> !$isunknown(i_wr_addr));

endmodule

/* src/codec_top.sv */
`include "viterbi_defines.svh"

module codec_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_start,
    input  viterbi_pkg::codec_mode_e    i_mode,
    input  viterbi_pkg::code_cfg_t      i_cfg,
    input  logic [`NUM_BITS_W-1:0]      i_num_bits,
    input  logic                        i_bit_valid,
    input  logic                        i_bit,
    input  viterbi_pkg::scan_idx_t      i_rd_addr,
    output logic                        o_busy,
    output logic                        o_done,
    output logic                        o_code_valid,
    output logic [`MAX_CODE_RATE-1:0]   o_code,
    output viterbi_pkg::branch_entry_t  o_rd_data
);
    import viterbi_pkg::*;

    code_cfg_t      cfg;            // latched config to datapath
    logic           clear;
    logic           enc_valid;
    logic           enc_bit;
    logic           scan_valid;
    scan_idx_t      scan_idx;
    logic           entry_valid;    // also times done in ctrl
    branch_entry_t  entry;
    scan_idx_t      wr_addr;

    assign wr_addr = '{state: entry.state, pair: entry.pair};  // entry's own address

    codec_ctrl u_ctrl
    (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .i_mode         (i_mode),
        .i_cfg          (i_cfg),
        .i_num_bits     (i_num_bits),
        .i_bit_valid    (i_bit_valid),
        .i_bit          (i_bit),
        .i_last_write   (entry_valid),
        .o_cfg          (cfg),
        .o_clear        (clear),
        .o_enc_valid    (enc_valid),
        .o_enc_bit      (enc_bit),
        .o_scan_valid   (scan_valid),
        .o_scan_idx     (scan_idx),
        .o_busy         (o_busy),
        .o_done         (o_done)
    );

    conv_encoder u_encoder
    (
        .clk            (clk),
        .rst            (rst),
        .i_cfg          (cfg),
        .i_clear        (clear),
        .i_enc_valid    (enc_valid),
        .i_enc_bit      (enc_bit),
        .i_scan_valid   (scan_valid),
        .i_scan_idx     (scan_idx),
        .o_code_valid   (o_code_valid),
        .o_code         (o_code),
        .o_entry_valid  (entry_valid),
        .o_entry        (entry)
    );

    trellis_table #(.payload_t(branch_entry_t)) u_table
    (
        .clk            (clk),
        .rst            (rst),
        .i_wr_en        (entry_valid),
        .i_wr_addr      (wr_addr),
        .i_wr_data      (entry),
        .i_rd_addr      (i_rd_addr),
        .o_rd_data      (o_rd_data)
    );

endmodule

/* verification/tb_codec.sv */
`include "viterbi_defines.svh"

module tb_codec;
    timeunit 1ns;
    timeprecision 100ps;
    import viterbi_pkg::*;

    logic                       clk;
    logic                       rst;
    logic                       i_start;
    codec_mode_e                i_mode;
    code_cfg_t                  i_cfg;
    logic [`NUM_BITS_W-1:0]     i_num_bits;
    logic                       i_bit_valid;
    logic                       i_bit;
    scan_idx_t                  i_rd_addr;
    logic                       o_busy;
    logic                       o_done;
    logic                       o_code_valid;
    logic [`MAX_CODE_RATE-1:0]  o_code;
    branch_entry_t              o_rd_data;

    int                         val_errs;       // wrong values
    int                         flow_errs;      // protocol and file problems
    int                         budget;         // watchdog limit in cycles
    int                         cycles;
    logic [31:0]                rng;

    codec_top DUT
    (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .i_mode         (i_mode),
        .i_cfg          (i_cfg),
        .i_num_bits     (i_num_bits),
        .i_bit_valid    (i_bit_valid),
        .i_bit          (i_bit),
        .i_rd_addr      (i_rd_addr),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_code_valid   (o_code_valid),
        .o_code         (o_code),
        .o_rd_data      (o_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    // parity of each tapped window with the third bit masked at rate 1/2
    function automatic logic [2:0] model_word(input code_cfg_t cfg, input logic [8:0] window);
        logic [2:0] w;
        for (int i = 0; i < 3; i++)
            w[i] = ^(window & cfg.gen_poly[i]);
        if (!cfg.code_rate)
            w[2] = 1'b0;
        return w;
    endfunction

    function automatic branch_entry_t model_entry(input code_cfg_t cfg, input logic [9:0] addr);
        branch_entry_t e;
        e.pair   = addr[1:0];
        e.state  = addr[9:2];
        e.first  = model_word(cfg, {addr[9:2], addr[0]});
        e.second = model_word(cfg, {addr[8:2], addr[0], addr[1]});  // shifted one more step
        return e;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [1:0] k_code(input int k);
        case (k)
            3:       return `CONSTR_K3;
            5:       return `CONSTR_K5;
            7:       return `CONSTR_K7;
            default: return `CONSTR_K9;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        val_errs++;
    endtask

    // pulse start with the given mode and check busy the cycle after
    task automatic start_run(input codec_mode_e mode, input code_cfg_t cfg,
                             input int nbits);
        i_mode     = mode;
        i_cfg      = cfg;
        i_num_bits = nbits[15:0];
        i_start    = 1'b1;
        @(posedge clk);
        #1;
        i_start    = 1'b0;
        if (o_busy !== 1'b1) report_mismatch("o_busy", o_busy, 1);
    endtask

    task automatic run_encode(input code_cfg_t cfg, input int nbits, input logic [15:0] bits,
                              input logic [63:0] codes);
        logic [7:0] hist;
        logic [2:0] exp;
        hist = '0;
        i_bit_valid = 1'b1;                     // idle strobes must be dropped
        i_bit       = 1'b1;
        @(posedge clk);
        #1;
        i_bit_valid = 1'b0;
        if (o_code_valid !== 1'b0) report_mismatch("o_code_valid", o_code_valid, 0);
        @(posedge clk);
        #1;
        if (o_code_valid !== 1'b0) report_mismatch("o_code_valid", o_code_valid, 0);
        start_run(MODE_ENCODE, cfg, nbits);
        for (int i = 0; i < nbits; i++)
        begin
            i_bit_valid = 1'b1;
            i_bit       = bits[i];
            if (i == 3)
            begin
                i_start = 1'b1;                 // stray start while busy
                i_mode  = MODE_TABLE;
            end
            exp = codes[4*i +: 3];
            if (exp !== model_word(cfg, {hist, bits[i]}))
            begin
                $display("case file code word %0d disagrees with the model", i);
                flow_errs++;
            end
            hist = {hist[6:0], bits[i]};
            @(posedge clk);
            #1;
            i_start = 1'b0;
            i_mode  = MODE_ENCODE;
            if (o_code_valid !== 1'b1) report_mismatch("o_code_valid", o_code_valid, 1);
            if (o_code !== exp) report_mismatch("o_code", o_code, exp);
            if (o_done !== (i == nbits - 1)) report_mismatch("o_done", o_done, i == nbits - 1);
        end
        i_bit_valid = 1'b0;
        if (o_busy !== 1'b0) report_mismatch("o_busy", o_busy, 0);
        @(posedge clk);
        #1;
        if (o_code_valid !== 1'b0) report_mismatch("o_code_valid", o_code_valid, 0);
        if (o_done !== 1'b0) report_mismatch("o_done", o_done, 0);
    endtask

    task automatic read_entry(input logic [9:0] addr, input branch_entry_t exp);
        i_rd_addr = scan_idx_t'(addr);
        @(posedge clk);
        #1;
        if (o_rd_data !== exp) report_mismatch("o_rd_data", o_rd_data, exp);
    endtask

    task automatic run_table(input code_cfg_t cfg, input int k,
                             input logic [9:0] addr [3], input logic [15:0] ent [3]);
        int n;
        int done_n;
        int done_at;
        logic [9:0] a;
        n       = 4 << (k - 1);                 // branches for this K
        done_n  = 0;
        done_at = 0;
        start_run(MODE_TABLE, cfg, 0);
        for (int cnt = 1; cnt <= n + 8; cnt++)  // bounded wait for done
        begin
            @(posedge clk);
            #1;
            i_start = (cnt == 5);               // stray start mid scan
            if (o_done === 1'b1)
            begin
                done_n++;
                if (done_n == 1)
                    done_at = cnt;
                if (o_busy !== 1'b0) report_mismatch("o_busy", o_busy, 0);
            end
        end
        i_start = 1'b0;
        if (done_n == 0)
        begin
            $display("table run K=%0d never pulsed o_done", k);
            flow_errs++;
        end
        else if (done_n != 1)
            report_mismatch("done pulses", done_n, 1);
        else if (done_at != n + 2)
            report_mismatch("done cycle", done_at, n + 2);
        for (int j = 0; j < 3; j++)
        begin
            if (ent[j] !== model_entry(cfg, addr[j]))
            begin
                $display("case file entry at %0h disagrees with the model", addr[j]);
                flow_errs++;
            end
            read_entry(addr[j], ent[j]);
        end
        for (int j = 0; j < 8; j++)
        begin
            rng = xorshift32(rng);
            a   = 10'(rng % n);                 // inside the scanned range
            read_entry(a, model_entry(cfg, a));
        end
    endtask

    // watchdog budget grows with every case read
    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > budget)
            begin
                $display("timeout after %0d cycles, run stopped by watchdog", cycles);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    initial
    begin
        int             fd;
        int             rc;
        logic [63:0]    kind;
        logic [8*200-1:0] line;
        int             rate;
        int             k;
        int             nbits;
        logic [8:0]     p [3];
        logic [15:0]    bits;
        logic [63:0]    codes;
        logic [9:0]     addr [3];
        logic [15:0]    ent [3];
        code_cfg_t      cfg;
        val_errs    = 0;
        flow_errs   = 0;
        budget      = 200;                      // reset plus margin
        rng         = 32'h61b2fae6;
        rst         = 1'b0;
        i_start     = 1'b0;
        i_mode      = MODE_ENCODE;
        i_cfg       = '0;
        i_num_bits  = '0;
        i_bit_valid = 1'b0;
        i_bit       = 1'b0;
        i_rd_addr   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        if (o_busy !== 1'b0) report_mismatch("o_busy", o_busy, 0);
        if (o_done !== 1'b0) report_mismatch("o_done", o_done, 0);
        if (o_code_valid !== 1'b0) report_mismatch("o_code_valid", o_code_valid, 0);
        fd = $fopen("verification/codec_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the case file verification/codec_cases.txt");
            flow_errs++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                kind = '0;
                rc   = $fscanf(fd, "%s", kind);
                if (rc != 1)
                    break;
                if (kind[7:0] == 8'h23)
                    rc = $fgets(line, fd);      // comment line
                else if (kind == "enc")
                begin
                    rc = $fscanf(fd, "%d %d %h %h %h %d %h %h",
                                 rate, k, p[0], p[1], p[2], nbits, bits, codes);
                    cfg = '{code_rate: rate[0], constr_len: k_code(k),
                            gen_poly: {p[2], p[1], p[0]}};
                    budget += 2 * (nbits + 8);
                    run_encode(cfg, nbits, bits, codes);
                    run_encode(cfg, nbits, bits, codes);   // back to back
                end
                else if (kind == "tab")
                begin
                    rc = $fscanf(fd, "%d %d %h %h %h %h %h %h %h %h %h",
                                 rate, k, p[0], p[1], p[2],
                                 addr[0], ent[0], addr[1], ent[1], addr[2], ent[2]);
                    cfg = '{code_rate: rate[0], constr_len: k_code(k),
                            gen_poly: {p[2], p[1], p[0]}};
                    budget += (4 << (k - 1)) + 40;
                    run_table(cfg, k, addr, ent);
                end
                else
                begin
                    $display("unknown line kind in the case file");
                    flow_errs++;
                end
            end
            $fclose(fd);
        end
        $display("errors: value %0d, protocol %0d", val_errs, flow_errs);
        if (val_errs == 0 && flow_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* verification/codec_cases.txt */
# enc rate K p0 p1 p2 nbits bits codes
#   bits hex with bit 0 sent first, codes hex with the code word of bit i in nibble i
# tab rate K p0 p1 p2 addr0 entry0 addr1 entry1 addr2 entry2
#   rate 0 is 1/2 and 1 is 1/3, polynomials hex with bit 0 on the newest bit
#
# K = 3, classic 7/5 code at rate 1/2
enc 0 3 007 005 000 8 004d 13322013
# K = 3 at rate 1/3
enc 1 3 007 005 003 8 004d 57362457
# K = 7 at rate 1/3, two spaced ones
enc 1 7 079 05b 065 10 0005 0754671327
# K = 9 impulse at rate 1/2, third polynomial masked
enc 0 9 1af 11d 155 10 0001 0310123313
#
# branch tables, entry is {pair, state, second, first}
tab 0 3 007 005 000 000 0000 006 8041 00f c0c9
tab 1 5 019 017 01d 025 4262 03e 83de 00b c081

/* flist.f */
+incdir+src
src/viterbi_pkg.sv
src/codec_ctrl.sv
src/conv_encoder.sv
src/trellis_table.sv
src/codec_top.sv
verification/tb_codec.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_codec
RTL_TOP   ?= codec_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^\*\* PASS \*\*$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
